// ==== core_consts.svh ====
// Width and size constants of the execute path, included by the packages and the RTL
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Datapath word width
`define CORE_DW    32

// Register file depth and index width
`define CORE_NREG  16
`define CORE_RW    4

// Operand source select width
`define CORE_SELW  2

// Instruction field widths
`define CORE_OPW   4
`define CORE_IMMW  16

`endif

// ==== ex_stage.sv ====
// Execute and write-back stages: EX control register, ALU, WB register and forward taps
`timescale 1ns/10ps
`include "core_consts.svh"

module ex_stage (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  id_freeze,
	input  logic                  ex_freeze,
	input  pipe_pkg::ex_ctl_t     id_ctl,
	input  logic [`CORE_DW-1:0]   operand_a,
	input  logic [`CORE_DW-1:0]   operand_b,
	output pipe_pkg::dest_t       ex_fwd,
	output pipe_pkg::dest_t       wb_fwd,
	output pipe_pkg::wb_result_t  wb
);
	import isa_pkg::*;
	import pipe_pkg::*;

	ex_ctl_t              ex_ctl;
	logic [`CORE_DW-1:0]  alu_y;
	dest_t                wb_q;
	// Set only on an edge that loads WB with a valid result
	logic                 wb_stb;

	//////////////////////////////////////////////////
	// EX control register
	//////////////////////////////////////////////////

	// ID freeze alone sends a bubble
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			ex_ctl <= '0;
		else if (ex_freeze)
			ex_ctl <= ex_ctl;
		else if (id_freeze)
			ex_ctl <= '0;
		else
			ex_ctl <= id_ctl;
	end

	// ALU, immediate opcodes share the register-format path
	always_comb begin
		case (ex_ctl.op)
			ADD, ADDI: alu_y = operand_a + operand_b;
			SUB:       alu_y = operand_a - operand_b;
			AND:       alu_y = operand_a & operand_b;
			OR:        alu_y = operand_a | operand_b;
			XOR, XORI: alu_y = operand_a ^ operand_b;
			default:   alu_y = '0;
		endcase
	end

	// EX tap is combinational
	assign ex_fwd = '{valid: ex_ctl.valid, rd: ex_ctl.rd, data: alu_y};

	//////////////////////////////////////////////////
	// WB register
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_q   <= '0;
			wb_stb <= 1'b0;
		end else begin
			if (!ex_freeze)
				wb_q <= ex_fwd;
			// No repeat strobe while WB holds
			wb_stb <= !ex_freeze && ex_ctl.valid;
		end
	end

	// Write port keeps its valid through a hold
	assign wb_fwd = wb_q;
	assign wb     = '{valid: wb_stb, rd: wb_q.rd, data: wb_q.data};

endmodule

// ==== exec_core.sv ====
// Top level of the execute path: decode, register file, operand muxes and execute
`timescale 1ns/10ps
`include "core_consts.svh"

module exec_core (
	input  logic                  clk,
	input  logic                  arst_n,
	input  isa_pkg::instr_u       instr,
	input  logic                  id_freeze,
	input  logic                  ex_freeze,
	output pipe_pkg::wb_result_t  wb
);
	import pipe_pkg::*;

	// Decode to register file and muxes
	logic [`CORE_RW-1:0]  rf_addr_a;
	logic [`CORE_RW-1:0]  rf_addr_b;
	logic [`CORE_DW-1:0]  simm;
	opsel_e               sel_a;
	opsel_e               sel_b;
	ex_ctl_t              id_ctl;

	// Register file read data
	logic [`CORE_DW-1:0]  rf_dataa;
	logic [`CORE_DW-1:0]  rf_datab;

	// Operands into EX
	logic [`CORE_DW-1:0]  operand_a;
	logic [`CORE_DW-1:0]  operand_b;

	// Forward taps, WB also writes the register file
	dest_t                ex_fwd;
	dest_t                wb_fwd;

	id_decode u_id_decode (
		.clk       (clk),
		.arst_n    (arst_n),
		.id_freeze (id_freeze),
		.instr     (instr),
		.ex_fwd    (ex_fwd),
		.wb_fwd    (wb_fwd),
		.rf_addr_a (rf_addr_a),
		.rf_addr_b (rf_addr_b),
		.simm      (simm),
		.sel_a     (sel_a),
		.sel_b     (sel_b),
		.id_ctl    (id_ctl)
	);

	reg_file u_reg_file (
		.clk       (clk),
		.arst_n    (arst_n),
		.rf_addr_a (rf_addr_a),
		.rf_addr_b (rf_addr_b),
		.wr        (wb_fwd),
		.rf_dataa  (rf_dataa),
		.rf_datab  (rf_datab)
	);

	operand_mux u_operand_mux (
		.clk       (clk),
		.arst_n    (arst_n),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.rf_dataa  (rf_dataa),
		.rf_datab  (rf_datab),
		.simm      (simm),
		.ex_fwd    (ex_fwd),
		.wb_fwd    (wb_fwd),
		.sel_a     (sel_a),
		.sel_b     (sel_b),
		.operand_a (operand_a),
		.operand_b (operand_b)
	);

	ex_stage u_ex_stage (
		.clk       (clk),
		.arst_n    (arst_n),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.id_ctl    (id_ctl),
		.operand_a (operand_a),
		.operand_b (operand_b),
		.ex_fwd    (ex_fwd),
		.wb_fwd    (wb_fwd),
		.wb        (wb)
	);

endmodule

// ==== id_decode.sv ====
// Decode stage: holds the instruction, decodes both formats and picks operand sources
`timescale 1ns/10ps
`include "core_consts.svh"

module id_decode (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 id_freeze,
	input  isa_pkg::instr_u      instr,
	input  pipe_pkg::dest_t      ex_fwd,
	input  pipe_pkg::dest_t      wb_fwd,
	output logic [`CORE_RW-1:0]  rf_addr_a,
	output logic [`CORE_RW-1:0]  rf_addr_b,
	output logic [`CORE_DW-1:0]  simm,
	output pipe_pkg::opsel_e     sel_a,
	output pipe_pkg::opsel_e     sel_b,
	output pipe_pkg::ex_ctl_t    id_ctl
);
	import isa_pkg::*;
	import pipe_pkg::*;

	// Instruction held in ID
	instr_u   id_instr;

	// Decoded fields
	opcode_e  id_op;
	logic     is_imm;
	logic     is_alu;

	// Forward source for one register index
	// EX wins over WB, r0 always comes from the register file
	function automatic opsel_e fwd_sel(
		input logic [`CORE_RW-1:0]  src,
		input dest_t                ex_d,
		input dest_t                wb_d
	);
		if (src == '0)
			return SEL_RF;
		else if (ex_d.valid && (ex_d.rd == src))
			return SEL_EX;
		else if (wb_d.valid && (wb_d.rd == src))
			return SEL_WB;
		else
			return SEL_RF;
	endfunction

	//////////////////////////////////////////////////
	// ID register
	//////////////////////////////////////////////////

	// Reset leaves a NOP in ID
	// Freeze keeps the current instruction
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			id_instr <= '0;
		else if (!id_freeze)
			id_instr <= instr;
	end

	//////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////

	// Opcode and register indices through the register view
	assign id_op     = id_instr.r.opcode;
	assign rf_addr_a = id_instr.r.ra;
	assign rf_addr_b = id_instr.r.rb;

	assign is_imm = (id_op == ADDI) || (id_op == XORI);
	assign is_alu = id_op inside {ADD, SUB, AND, OR, XOR, ADDI, XORI};

	// Immediate through the immediate view, sign extended
	assign simm = {{(`CORE_DW-`CORE_IMMW){id_instr.i.imm[`CORE_IMMW-1]}}, id_instr.i.imm};

	// Operand sources
	assign sel_a = fwd_sel(id_instr.r.ra, ex_fwd, wb_fwd);
	assign sel_b = is_imm ? SEL_IMM : fwd_sel(id_instr.r.rb, ex_fwd, wb_fwd);

	// Unknown opcodes travel as bubbles
	assign id_ctl = '{valid: is_alu, op: id_op, rd: id_instr.r.rd};

endmodule

// ==== isa_pkg.sv ====
// Instruction set types of the execute path, shared by decode and execute
`include "core_consts.svh"

package isa_pkg;

	//////////////////////////////////////////////////
	// Opcodes
	//////////////////////////////////////////////////

	// Encodings above XORI are treated as no-ops by decode
	typedef enum logic [`CORE_OPW-1:0] {
		NOP  = 4'd0,
		ADD  = 4'd1,
		SUB  = 4'd2,
		AND  = 4'd3,
		OR   = 4'd4,
		XOR  = 4'd5,
		ADDI = 4'd6,
		XORI = 4'd7
	} opcode_e;

	//////////////////////////////////////////////////
	// Instruction formats
	//////////////////////////////////////////////////

	// Register format, rd = ra op rb
	typedef struct packed {
		opcode_e                opcode;
		logic [`CORE_RW-1:0]    rd;
		logic [`CORE_RW-1:0]    ra;
		logic [`CORE_RW-1:0]    rb;
		logic [`CORE_IMMW-1:0]  unused;
	} r_fmt_t;

	// Immediate format, rd = ra op sext(imm)
	// Reserved nibble sits where rb lives in the register format
	typedef struct packed {
		opcode_e                opcode;
		logic [`CORE_RW-1:0]    rd;
		logic [`CORE_RW-1:0]    ra;
		logic [`CORE_RW-1:0]    rsvd;
		logic [`CORE_IMMW-1:0]  imm;
	} i_fmt_t;

	// One word, two views
	// Opcode picks which view is meaningful
	typedef union packed {
		r_fmt_t  r;
		i_fmt_t  i;
	} instr_u;

endpackage

// ==== operand_mux.sv ====
// Operand muxes and operand registers between decode and execute, with hold on freeze
`timescale 1ns/10ps
`include "core_consts.svh"

module operand_mux (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 id_freeze,
	input  logic                 ex_freeze,
	input  logic [`CORE_DW-1:0]  rf_dataa,
	input  logic [`CORE_DW-1:0]  rf_datab,
	input  logic [`CORE_DW-1:0]  simm,
	input  pipe_pkg::dest_t      ex_fwd,
	input  pipe_pkg::dest_t      wb_fwd,
	input  pipe_pkg::opsel_e     sel_a,
	input  pipe_pkg::opsel_e     sel_b,
	output logic [`CORE_DW-1:0]  operand_a,
	output logic [`CORE_DW-1:0]  operand_b
);
	import pipe_pkg::*;

	// Index 0 is operand A, index 1 is operand B
	opsel_e                      sel_v [2];
	logic [1:0][`CORE_DW-1:0]    rf_v;
	logic [1:0][`CORE_DW-1:0]    muxed;
	logic [1:0][`CORE_DW-1:0]    operand_q;
	logic [1:0]                  saved;

	assign sel_v[0] = sel_a;
	assign sel_v[1] = sel_b;
	assign rf_v     = {rf_datab, rf_dataa};

	//////////////////////////////////////////////////
	// Source muxes
	//////////////////////////////////////////////////

	// Decode never asks for the immediate on operand A
	always_comb begin
		for (int k = 0; k < 2; k++) begin
			case (sel_v[k])
				SEL_IMM: muxed[k] = simm;
				SEL_EX:  muxed[k] = ex_fwd.data;
				SEL_WB:  muxed[k] = wb_fwd.data;
				default: muxed[k] = rf_v[k];
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Operand registers
	//////////////////////////////////////////////////

	// First ID freeze cycle saves the operand and sets the flag
	// Saved value then holds until both freezes drop
	// ex_freeze holds everything
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			operand_q <= '0;
			saved     <= '0;
		end else begin
			for (int k = 0; k < 2; k++) begin
				if (!ex_freeze && id_freeze && !saved[k]) begin
					operand_q[k] <= muxed[k];
					saved[k]     <= 1'b1;
				end else if (!ex_freeze && !saved[k]) begin
					operand_q[k] <= muxed[k];
				end else if (!ex_freeze && !id_freeze) begin
					saved[k] <= 1'b0;
				end
			end
		end
	end

	assign operand_a = operand_q[0];
	assign operand_b = operand_q[1];

endmodule

// ==== operand_mux_assert.sv ====
// Concurrent checks on the operand registers, bound into every operand_mux instance
`timescale 1ns/10ps
`include "core_consts.svh"

module operand_mux_assert (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 ex_freeze,
	input  pipe_pkg::opsel_e     sel_a,
	input  pipe_pkg::opsel_e     sel_b,
	input  logic [`CORE_DW-1:0]  operand_a,
	input  logic [`CORE_DW-1:0]  operand_b
);

	// Failures seen so far, read by the testbench top
	int unsigned fail_cnt = 0;

	// Reset edge leaves both operands at zero
	reset_clears: assert property (@(posedge clk)
		!arst_n |=> ((operand_a == '0) && (operand_b == '0)))
		else begin
			fail_cnt++;
			$error("operand register not cleared by reset");
		end

	// EX freeze keeps the operands of the held instruction
	hold_on_ex_freeze: assert property (@(posedge clk) disable iff (!arst_n)
		ex_freeze |=> ($stable(operand_a) && $stable(operand_b)))
		else begin
			fail_cnt++;
			$error("operand changed while EX was frozen");
		end

	// Decode always drives a defined source
	sel_known: assert property (@(posedge clk) disable iff (!arst_n)
		!$isunknown({sel_a, sel_b}))
		else begin
			fail_cnt++;
			$error("operand select is unknown");
		end

endmodule

bind operand_mux operand_mux_assert u_operand_mux_assert (
	.clk       (clk),
	.arst_n    (arst_n),
	.ex_freeze (ex_freeze),
	.sel_a     (sel_a),
	.sel_b     (sel_b),
	.operand_a (operand_a),
	.operand_b (operand_b)
);

// ==== pipe_pkg.sv ====
// Stage-to-stage pipeline types, shared by the decode, operand and execute stages
`include "core_consts.svh"

package pipe_pkg;

	// Operand source, only operand B may take the immediate
	typedef enum logic [`CORE_SELW-1:0] {
		SEL_RF  = 2'd0,
		SEL_IMM = 2'd1,
		SEL_EX  = 2'd2,
		SEL_WB  = 2'd3
	} opsel_e;

	// Control word carried from ID into EX
	typedef struct packed {
		logic                 valid;
		isa_pkg::opcode_e     op;
		logic [`CORE_RW-1:0]  rd;
	} ex_ctl_t;

	// Destination tap for forwarding and the register write port
	typedef struct packed {
		logic                 valid;
		logic [`CORE_RW-1:0]  rd;
		logic [`CORE_DW-1:0]  data;
	} dest_t;

	// Retired result seen at the top level
	typedef struct packed {
		logic                 valid;
		logic [`CORE_RW-1:0]  rd;
		logic [`CORE_DW-1:0]  data;
	} wb_result_t;

endpackage

// ==== reg_file.sv ====
// Register file: two combinational read ports and one write port, r0 reads as zero
`timescale 1ns/10ps
`include "core_consts.svh"

module reg_file (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic [`CORE_RW-1:0]  rf_addr_a,
	input  logic [`CORE_RW-1:0]  rf_addr_b,
	input  pipe_pkg::dest_t      wr,
	output logic [`CORE_DW-1:0]  rf_dataa,
	output logic [`CORE_DW-1:0]  rf_datab
);

	logic [`CORE_DW-1:0] regs [`CORE_NREG];

	// Write at the edge, writes to r0 are dropped
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `CORE_NREG; i++)
				regs[i] <= '0;
		end else if (wr.valid && (wr.rd != '0)) begin
			regs[wr.rd] <= wr.data;
		end
	end

	// Reads see the old value during a write
	// WB forwarding covers that overlap
	assign rf_dataa = (rf_addr_a == '0) ? '0 : regs[rf_addr_a];
	assign rf_datab = (rf_addr_b == '0) ? '0 : regs[rf_addr_b];

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the execute path testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary -f tb.f --top-module tb_top -o sim_exec_core
./obj_dir/sim_exec_core +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
	exit 1
fi
exit 0

// ==== tb.f ====
+incdir+.
isa_pkg.sv
pipe_pkg.sv
id_decode.sv
reg_file.sv
operand_mux.sv
ex_stage.sv
exec_core.sv
operand_mux_assert.sv
wb_checker.sv
tb_top.sv

// ==== tb_top.sv ====
// Testbench top that applies the stimulus table to the execute path and reports the result
`timescale 1ns/10ps
`include "core_consts.svh"

module tb_top;
	import isa_pkg::*;
	import pipe_pkg::*;

	localparam int CLK_PERIOD = 100;
	// Longest wait for the pipeline to empty after the table
	localparam int DRAIN_MAX  = 16;

	// Stimulus row
	// rnd picks random freeze levels
	typedef struct packed {
		logic [79:0]  name;
		instr_u       word;
		logic         id_fz;
		logic         ex_fz;
		logic         rnd;
	} row_t;

	logic         clk;
	logic         arst_n;
	instr_u       instr;
	logic         id_freeze;
	logic         ex_freeze;
	wb_result_t   wb;
	logic [79:0]  test_name;
	logic         final_check;
	int unsigned  value_errs;
	int unsigned  orphan_errs;
	int unsigned  left_errs;
	int unsigned  pending;
	int unsigned  total;
	row_t         rows [$];
	int           n_rows = 0;
	integer       seed;

	always #(CLK_PERIOD / 2) clk = ~clk;

	exec_core DUT (
		.clk       (clk),
		.arst_n    (arst_n),
		.instr     (instr),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.wb        (wb)
	);

	wb_checker u_wb_checker (
		.clk         (clk),
		.arst_n      (arst_n),
		.instr       (instr),
		.id_freeze   (id_freeze),
		.wb          (wb),
		.test_name   (test_name),
		.final_check (final_check),
		.value_errs  (value_errs),
		.orphan_errs (orphan_errs),
		.left_errs   (left_errs),
		.pending     (pending)
	);

	//////////////////////////////////////////////////
	// Instruction words and table rows
	//////////////////////////////////////////////////

	function automatic instr_u r_word(input opcode_e op, input int rd, input int ra, input int rb);
		instr_u w;
		w.r = '{op, rd[`CORE_RW-1:0], ra[`CORE_RW-1:0], rb[`CORE_RW-1:0], 16'h0};
		return w;
	endfunction

	function automatic instr_u i_word(input opcode_e op, input int rd, input int ra, input int imm);
		instr_u w;
		w.i = '{op, rd[`CORE_RW-1:0], ra[`CORE_RW-1:0], 4'h0, imm[`CORE_IMMW-1:0]};
		return w;
	endfunction

	task automatic add_op(input logic [79:0] name, input instr_u w);
		rows.push_back(row_t'{name: name, word: w, id_fz: 1'b0, ex_fz: 1'b0, rnd: 1'b0});
	endtask

	// NOP row with fixed freeze levels
	task automatic add_idle(input logic [79:0] name, input logic idf, input logic exf);
		rows.push_back(row_t'{name: name, word: '0, id_fz: idf, ex_fz: exf, rnd: 1'b0});
	endtask

	task automatic add_rand(input logic [79:0] name);
		rows.push_back(row_t'{name: name, word: '0, id_fz: 1'b0, ex_fz: 1'b0, rnd: 1'b1});
	endtask

	task automatic build_table;
		// Seed registers including negative immediates
		add_op("init      ", i_word(ADDI, 1, 0, 'h0123));
		add_op("init      ", i_word(ADDI, 2, 0, 'h7abc));
		add_op("init      ", i_word(ADDI, 3, 0, -3));
		add_op("init      ", i_word(XORI, 4, 0, 'h8001));
		add_idle("init      ", 1'b0, 1'b0);
		add_idle("init      ", 1'b0, 1'b0);
		// Sources far enough back to come from the register file
		add_op("alu_rf    ", r_word(ADD, 5, 1, 2));
		add_op("alu_rf    ", r_word(SUB, 6, 2, 3));
		add_op("alu_rf    ", r_word(AND, 7, 4, 2));
		add_op("alu_rf    ", r_word(OR, 8, 3, 1));
		add_op("alu_rf    ", r_word(XOR, 9, 4, 1));
		add_op("imm_neg   ", i_word(ADDI, 10, 2, 'h8000));
		add_op("imm_neg   ", i_word(XORI, 11, 1, 'hffff));
		// r11 from EX, r10 from WB, then both from EX
		add_op("fwd_ex    ", r_word(SUB, 12, 11, 10));
		add_op("fwd_ex    ", r_word(ADD, 13, 12, 12));
		add_op("fwd_wb    ", r_word(XOR, 14, 12, 13));
		add_op("fwd_wb    ", i_word(ADDI, 6, 0, 9));
		add_op("fwd_wb    ", r_word(AND, 8, 14, 5));
		// r15 sits in EX and WB at once
		add_op("fwd_prio  ", i_word(ADDI, 15, 0, 1));
		add_op("fwd_prio  ", i_word(ADDI, 15, 15, 2));
		add_op("fwd_prio  ", r_word(ADD, 1, 15, 15));
		// r0 results must never reach a later operand
		add_op("r0_drop   ", i_word(ADDI, 0, 1, 'h55));
		add_op("r0_drop   ", r_word(ADD, 2, 0, 1));
		add_op("r0_drop   ", r_word(OR, 3, 0, 2));
		// Single ID freeze and a run of them
		add_op("id_frz    ", r_word(ADD, 4, 3, 2));
		add_idle("id_frz    ", 1'b1, 1'b0);
		add_op("id_frz    ", r_word(SUB, 5, 4, 3));
		repeat (3) add_idle("id_frz    ", 1'b1, 1'b0);
		add_op("id_frz    ", r_word(XOR, 6, 5, 4));
		add_op("id_frz    ", i_word(ADDI, 7, 6, -1));
		// EX freezes mixed with ID freezes
		add_op("ex_frz    ", r_word(ADD, 8, 7, 6));
		repeat (2) add_idle("ex_frz    ", 1'b1, 1'b1);
		add_op("ex_frz    ", r_word(SUB, 9, 8, 7));
		add_idle("ex_frz    ", 1'b1, 1'b0);
		add_idle("ex_frz    ", 1'b1, 1'b1);
		add_idle("ex_frz    ", 1'b1, 1'b0);
		add_op("ex_frz    ", r_word(AND, 10, 9, 8));
		add_op("ex_frz    ", r_word(OR, 11, 10, 9));
		// Random stall rows between dependent instructions
		add_op("rand_frz  ", r_word(ADD, 12, 11, 10));
		add_rand("rand_frz  ");
		add_op("rand_frz  ", r_word(XOR, 13, 12, 11));
		repeat (2) add_rand("rand_frz  ");
		add_op("rand_frz  ", r_word(SUB, 14, 13, 12));
		add_rand("rand_frz  ");
		add_op("rand_frz  ", i_word(ADDI, 15, 14, -100));
		repeat (3) add_rand("rand_frz  ");
		add_op("rand_frz  ", r_word(ADD, 1, 15, 14));
		add_op("rand_frz  ", r_word(OR, 2, 1, 15));
		add_rand("rand_frz  ");
		add_op("rand_frz  ", i_word(XORI, 3, 2, 'h1234));
		add_rand("rand_frz  ");
		// Pipeline drain
		repeat (6) add_idle("drain     ", 1'b0, 1'b0);
	endtask

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	initial begin
		row_t         row;
		logic         idf;
		logic         exf;
		logic [31:0]  rv;
		int           drain;
		int unsigned  asrt_errs;

		clk         = 1'b0;
		arst_n      = 1'b0;
		instr       = '0;
		id_freeze   = 1'b0;
		ex_freeze   = 1'b0;
		test_name   = "reset     ";
		final_check = 1'b0;
		seed        = 32'ha335fbbe;
		build_table();
		n_rows = rows.size();

		repeat (2) @(posedge clk);
		arst_n <= 1'b1;

		for (int i = 0; i < n_rows; i++) begin
			row = rows[i];
			idf = row.id_fz;
			exf = row.ex_fz;
			// EX freeze only together with ID freeze
			if (row.rnd) begin
				rv  = $random(seed);
				idf = rv[0];
				exf = rv[0] & rv[1];
			end
			@(posedge clk);
			instr     <= row.word;
			id_freeze <= idf;
			ex_freeze <= exf;
			test_name <= row.name;
		end

		// Bounded wait for the pipeline to empty
		// Whatever is still queued afterwards counts as unretired
		drain = 0;
		while ((pending != 0) && (drain < DRAIN_MAX)) begin
			@(posedge clk);
			drain++;
		end
		// Window for stray strobes
		repeat (3) @(posedge clk);
		final_check <= 1'b1;
		@(posedge clk);
		final_check <= 1'b0;
		@(posedge clk);

		asrt_errs = DUT.u_operand_mux.u_operand_mux_assert.fail_cnt;
		total     = value_errs + orphan_errs + left_errs + asrt_errs;
		$display("counts: %0d wrong result, %0d orphan strobe, %0d unretired, %0d assertion",
			value_errs, orphan_errs, left_errs, asrt_errs);
		if (total == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	// Watchdog allows four cycles per row plus reset and drain margin
	initial begin
		wait (n_rows != 0);
		repeat (n_rows * 4 + 20) @(posedge clk);
		$display("timeout: pipeline did not drain within %0d cycles", n_rows * 4 + 20);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== wb_checker.sv ====
// Reference model instantiated by the testbench top to compare every retired result in ISA order
`timescale 1ns/10ps
`include "core_consts.svh"

module wb_checker (
	input  logic                  clk,
	input  logic                  arst_n,
	input  isa_pkg::instr_u       instr,
	input  logic                  id_freeze,
	input  pipe_pkg::wb_result_t  wb,
	input  logic [79:0]           test_name,
	input  logic                  final_check,
	output int unsigned           value_errs,
	output int unsigned           orphan_errs,
	output int unsigned           left_errs,
	output int unsigned           pending
);
	import isa_pkg::*;
	import pipe_pkg::*;

	// Expected result tagged with the issuing test and its acceptance edge
	typedef struct packed {
		logic [79:0]          name;
		logic [31:0]          acc;
		logic [`CORE_RW-1:0]  rd;
		logic [`CORE_DW-1:0]  data;
	} expect_t;

	// Architectural registers in program order
	logic [`CORE_DW-1:0]  model_rf [`CORE_NREG];
	expect_t              exp_q [$];
	int unsigned          n_value;
	int unsigned          n_orphan;
	int unsigned          n_left;
	// Edge count and the last edge that saw a freeze
	logic [31:0]          cyc;
	logic [31:0]          frz_cyc;

	// ISA result where immediate opcodes get b already sign extended
	function automatic logic [`CORE_DW-1:0] alu_ref(
		input opcode_e              op,
		input logic [`CORE_DW-1:0]  a,
		input logic [`CORE_DW-1:0]  b
	);
		case (op)
			ADD, ADDI: return a + b;
			SUB:       return a - b;
			AND:       return a & b;
			OR:        return a | b;
			XOR, XORI: return a ^ b;
			default:   return '0;
		endcase
	endfunction

	//////////////////////////////////////////////////
	// Retire and accept
	//////////////////////////////////////////////////

	// Inputs and wb are sampled as they stood before the edge
	always @(posedge clk) begin
		expect_t              head;
		expect_t              ent;
		opcode_e              op;
		logic [`CORE_DW-1:0]  a;
		logic [`CORE_DW-1:0]  b;

		if (!arst_n) begin
			for (int r = 0; r < `CORE_NREG; r++)
				model_rf[r] = '0;
			exp_q.delete();
			n_value  = 0;
			n_orphan = 0;
			n_left   = 0;
			cyc      = '0;
			frz_cyc  = '0;
		end else begin
			cyc = cyc + 1;

			// A strobe retires the oldest pending instruction
			// Strobe is seen one edge after WB loads, so three edges after acceptance
			if (wb.valid) begin
				if (exp_q.size() == 0) begin
					n_orphan++;
					$display("result for rd %0d appeared with no instruction pending", wb.rd);
				end else begin
					head = exp_q.pop_front();
					if ((head.rd != wb.rd) || (head.data != wb.data)) begin
						n_value++;
						$display("error %s: expected rd %0d data %08h, actual rd %0d data %08h",
							head.name, head.rd, head.data, wb.rd, wb.data);
					end else if ((frz_cyc < head.acc) && ((cyc - head.acc) != 32'd3)) begin
						n_value++;
						$display("error %s: expected latency %0d edges, actual %0d edges",
							head.name, 2, cyc - head.acc - 1);
					end
				end
			end

			// Any freeze after acceptance lifts the latency check
			if (id_freeze)
				frz_cyc = cyc;

			// Accepted ALU instruction
			// r0 writes are dropped
			op = instr.r.opcode;
			if (!id_freeze && (op inside {ADD, SUB, AND, OR, XOR, ADDI, XORI})) begin
				a = model_rf[instr.r.ra];
				if ((op == ADDI) || (op == XORI))
					b = {{(`CORE_DW-`CORE_IMMW){instr.i.imm[`CORE_IMMW-1]}}, instr.i.imm};
				else
					b = model_rf[instr.r.rb];
				ent = '{name: test_name, acc: cyc, rd: instr.r.rd, data: alu_ref(op, a, b)};
				exp_q.push_back(ent);
				if (instr.r.rd != '0)
					model_rf[instr.r.rd] = ent.data;
			end

			// Anything still queued at the end of the run never retired
			if (final_check) begin
				n_left = exp_q.size();
				if (n_left != 0)
					$display("%0d accepted instructions were left unretired", n_left);
			end
		end

		value_errs  <= n_value;
		orphan_errs <= n_orphan;
		left_errs   <= n_left;
		pending     <= exp_q.size();
	end

endmodule
